//--- common/mem_map_pkg.sv
package mem_map_pkg;

  localparam int addr_w = 12;  // byte address, both memories

  // default depths in words
  localparam int def_pmem_depth = 1024;
  localparam int def_dmem_depth = 1024;

  typedef enum logic {
    HOST_RD,
    HOST_WR
  } host_op_t;

  typedef enum logic [1:0] {
    SPACE_PMEM,
    SPACE_DMEM,
    SPACE_STAT  // loader status block
  } host_space_t;

  typedef struct packed {
    host_op_t          op;
    host_space_t       space;
    logic [addr_w-1:0] addr;
    logic [15:0]       wdata;
    logic              byt;   // single byte write, lane from addr[0]
  } host_req_t;

  typedef struct packed {
    logic [17:0] rdata;
  } host_rsp_t;

endpackage

//--- common/img_load_pkg.sv
package img_load_pkg;

  typedef enum logic [2:0] {
    LD_WAIT,   // waiting for first sync byte
    LD_SYNC2,
    LD_META,   // pmem word count, dmem byte count
    LD_PMEM,
    LD_DMEM,
    LD_FIN
  } load_state_t;

  localparam logic [7:0] SYNC_HI = 8'h55;
  localparam logic [7:0] SYNC_LO = 8'hAA;

  typedef struct packed {
    logic [17:0] data;
    logic        last_meta;  // second meta word
  } asm_word_t;

endpackage

//--- hw/sync_ram.sv
module sync_ram import mem_map_pkg::*; #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 1024
) (
  input  logic              rst,
  input  logic [addr_w-1:0] addr,
  input  logic              we,
  input  logic              byt,
  input  logic [WIDTH-1:0]  wdata,
  output logic [WIDTH-1:0]  rdata
);

  localparam int idx_w     = $clog2(DEPTH);
  localparam bit byte_addr = WIDTH == 16;  // data memory

  logic [WIDTH-1:0]  mem [DEPTH];
  logic [addr_w-1:0] word_addr;
  logic [idx_w-1:0]  idx;

  assign word_addr = byte_addr ? {1'b0, addr[addr_w-1:1]} : addr;
  assign idx       = word_addr[idx_w-1:0];

  always_ff @(posedge rst) begin
    if (we) begin
      if (!byt) mem[idx] <= wdata;
      else if (addr[0]) mem[idx][15:8] <= wdata[7:0];
      else mem[idx][7:0] <= wdata[7:0];
    end
    rdata <= mem[idx];  // old data on a write
  end

endmodule

//--- img_loader/img_word_asm.sv
module img_word_asm import img_load_pkg::*; (
  input  logic        rst,
  input  logic        clk,
  input  logic        byte_valid,
  input  logic [7:0]  byte_data,
  output logic        byte_ready,
  input  load_state_t load_state,
  output logic        asm_valid,
  output asm_word_t   asm_word
);

  load_state_t eff_state;
  logic [1:0]  need;
  logic [1:0]  phase;
  logic        meta_second;
  logic        last_q;
  logic        accept;
  logic        word_done;
  logic [17:0] word_data;

  // controller enters LD_META one cycle after the second sync byte,
  // a byte in that cycle already belongs to the meta block
  assign eff_state = (load_state == LD_SYNC2 && asm_valid && word_data[7:0] == SYNC_LO) ?
                     LD_META : load_state;

  always_comb begin
    case (eff_state)
      LD_META, LD_DMEM: need = 2'd2;
      LD_PMEM:          need = 2'd3;
      default:          need = 2'd1;  // sync bytes one at a time
    endcase
  end

  assign byte_ready = load_state != LD_FIN;
  assign accept     = byte_valid & byte_ready;
  assign word_done  = accept && phase >= need - 2'd1;

  assign asm_word = '{data: word_data, last_meta: last_q};

  always_ff @(posedge rst, posedge clk) begin
    if (clk) begin
      phase       <= 2'd0;
      asm_valid   <= 1'b0;
      meta_second <= 1'b0;
      last_q      <= 1'b0;
    end else begin
      asm_valid <= word_done;
      last_q    <= word_done && eff_state == LD_META && meta_second;
      if (load_state == LD_FIN || word_done) phase <= 2'd0;
      else if (accept) phase <= phase + 2'd1;
      if (eff_state != LD_META) meta_second <= 1'b0;
      else if (word_done) meta_second <= ~meta_second;
    end
  end

  // high bits first, first byte of a word clears the rest
  always_ff @(posedge rst) begin
    if (accept) begin
      if (phase == 2'd0) word_data <= {10'd0, byte_data};
      else word_data <= {word_data[9:0], byte_data};
    end
  end

endmodule

//--- img_loader/img_load_ctrl.sv
module img_load_ctrl import mem_map_pkg::*, img_load_pkg::*; #(
  parameter logic [addr_w-1:0] DMEM_GVAR_START = addr_w'('h100)
) (
  input  logic              rst,
  input  logic              clk,
  input  logic              asm_valid,
  input  asm_word_t         asm_word,
  output load_state_t       load_state,
  output logic              loading,
  output logic [addr_w-1:0] ld_addr,
  output logic              ld_pmem_we,
  output logic              ld_dmem_we,
  output logic [17:0]       ld_wdata,
  output logic [addr_w-1:0] pmem_size,
  output logic [addr_w-1:0] dmem_size
);

  logic [addr_w-1:0] meta_val;
  logic [addr_w-1:0] dmem_end;
  logic              pmem_last;
  logic              dmem_last;

  assign meta_val  = asm_word.data[addr_w-1:0];
  assign dmem_end  = DMEM_GVAR_START + dmem_size;
  assign pmem_last = ld_addr == pmem_size - 1'b1;
  assign dmem_last = ld_addr + addr_w'(2) >= dmem_end;  // odd byte count rounds up

  assign loading = load_state inside {LD_META, LD_PMEM, LD_DMEM, LD_FIN};

  // write in the cycle the word is presented
  assign ld_pmem_we = asm_valid && load_state == LD_PMEM;
  assign ld_dmem_we = asm_valid && load_state == LD_DMEM;
  assign ld_wdata   = asm_word.data;

  always_ff @(posedge rst, posedge clk) begin
    if (clk) begin
      load_state <= LD_WAIT;
      ld_addr    <= '0;
      pmem_size  <= '0;
      dmem_size  <= '0;
    end else if (load_state == LD_FIN) begin
      load_state <= LD_WAIT;
    end else if (asm_valid) begin
      case (load_state)
        LD_WAIT:
          if (asm_word.data[7:0] == SYNC_HI) load_state <= LD_SYNC2;
        LD_SYNC2:
          if (asm_word.data[7:0] == SYNC_LO) begin
            load_state <= LD_META;
            pmem_size  <= '0;  // fresh image
            dmem_size  <= '0;
          end else begin
            load_state <= LD_WAIT;
          end
        LD_META:
          if (!asm_word.last_meta) begin
            pmem_size <= meta_val;
          end else begin
            dmem_size <= meta_val;
            if (pmem_size != '0) begin
              load_state <= LD_PMEM;
              ld_addr    <= '0;
            end else if (meta_val != '0) begin
              load_state <= LD_DMEM;
              ld_addr    <= DMEM_GVAR_START;
            end else begin
              load_state <= LD_FIN;
            end
          end
        LD_PMEM:
          if (!pmem_last) begin
            ld_addr <= ld_addr + 1'b1;
          end else if (dmem_size != '0) begin
            load_state <= LD_DMEM;
            ld_addr    <= DMEM_GVAR_START;
          end else begin
            load_state <= LD_FIN;
          end
        LD_DMEM:
          if (dmem_last) load_state <= LD_FIN;
          else ld_addr <= ld_addr + addr_w'(2);  // byte addressed
        default: ;
      endcase
    end
  end

endmodule

//--- hw/mem_port_mux.sv
module mem_port_mux import mem_map_pkg::*; (
  input  logic              rst,
  input  logic              clk,
  input  logic              loading,
  input  logic [addr_w-1:0] ld_addr,
  input  logic              ld_pmem_we,
  input  logic              ld_dmem_we,
  input  logic [17:0]       ld_wdata,
  input  logic [addr_w-1:0] pmem_size,
  input  logic [addr_w-1:0] dmem_size,
  input  logic              host_valid,
  input  host_req_t         host_req,
  output logic              host_ready,
  output logic              host_rsp_valid,
  output host_rsp_t         host_rsp,
  output logic [addr_w-1:0] pmem_addr,
  output logic              pmem_we,
  output logic              pmem_byt,
  output logic [17:0]       pmem_wdata,
  input  logic [17:0]       pmem_rdata,
  output logic [addr_w-1:0] dmem_addr,
  output logic              dmem_we,
  output logic              dmem_byt,
  output logic [15:0]       dmem_wdata,
  input  logic [15:0]       dmem_rdata
);

  host_space_t       rd_space_q;
  logic [addr_w-1:0] stat_val;
  logic [addr_w-1:0] stat_q;
  logic              host_acc;
  logic              host_wr;

  assign host_ready = ~loading;  // loader owns both rams
  assign host_acc   = host_valid & host_ready;
  assign host_wr    = host_acc && host_req.op == HOST_WR;

  assign pmem_addr  = loading ? ld_addr : host_req.addr;
  assign pmem_we    = loading ? ld_pmem_we : host_wr && host_req.space == SPACE_PMEM;
  assign pmem_byt   = ~loading & host_req.byt;
  assign pmem_wdata = loading ? ld_wdata : {2'b00, host_req.wdata};

  assign dmem_addr  = loading ? ld_addr : host_req.addr;
  assign dmem_we    = loading ? ld_dmem_we : host_wr && host_req.space == SPACE_DMEM;
  assign dmem_byt   = ~loading & host_req.byt;
  assign dmem_wdata = loading ? ld_wdata[15:0] : host_req.wdata;

  always_comb begin
    case (host_req.addr)
      addr_w'(0): stat_val = {{(addr_w-1){1'b0}}, loading};
      addr_w'(2): stat_val = pmem_size;
      addr_w'(4): stat_val = dmem_size;
      default:    stat_val = '0;
    endcase
  end

  always_ff @(posedge rst, posedge clk) begin
    if (clk) begin
      host_rsp_valid <= 1'b0;
      rd_space_q     <= SPACE_PMEM;
    end else begin
      host_rsp_valid <= host_acc && host_req.op == HOST_RD;
      if (host_acc) rd_space_q <= host_req.space;
    end
  end

  always_ff @(posedge rst) begin
    if (host_acc) stat_q <= stat_val;
  end

  // ram data is already registered, lines up with host_rsp_valid
  always_comb begin
    case (rd_space_q)
      SPACE_PMEM: host_rsp.rdata = pmem_rdata;
      SPACE_DMEM: host_rsp.rdata = {2'b00, dmem_rdata};
      default:    host_rsp.rdata = {{(18-addr_w){1'b0}}, stat_q};
    endcase
  end

endmodule

//--- hw/boot_loader_top.sv
module boot_loader_top import mem_map_pkg::*, img_load_pkg::*; #(
  parameter int                PMEM_DEPTH      = def_pmem_depth,
  parameter int                DMEM_DEPTH      = def_dmem_depth,
  parameter logic [addr_w-1:0] DMEM_GVAR_START = addr_w'('h100)
) (
  input  logic       rst,
  input  logic       clk,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,
  input  logic       host_valid,
  input  host_req_t  host_req,
  output logic       host_ready,
  output logic       host_rsp_valid,
  output host_rsp_t  host_rsp,
  output logic       loading
);

  load_state_t       load_state;
  asm_word_t         asm_word;
  logic              asm_valid;
  logic [addr_w-1:0] ld_addr;
  logic              ld_pmem_we;
  logic              ld_dmem_we;
  logic [17:0]       ld_wdata;
  logic [addr_w-1:0] pmem_size;
  logic [addr_w-1:0] dmem_size;
  logic [addr_w-1:0] pmem_addr;
  logic [addr_w-1:0] dmem_addr;
  logic              pmem_we;
  logic              dmem_we;
  logic              pmem_byt;
  logic              dmem_byt;
  logic [17:0]       pmem_wdata;
  logic [17:0]       pmem_rdata;
  logic [15:0]       dmem_wdata;
  logic [15:0]       dmem_rdata;

  img_word_asm u_img_word_asm (
    .rst        (rst),
    .clk        (clk),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_ready (byte_ready),
    .load_state (load_state),
    .asm_valid  (asm_valid),
    .asm_word   (asm_word)
  );

  img_load_ctrl #(.DMEM_GVAR_START(DMEM_GVAR_START)) u_img_load_ctrl (
    .rst        (rst),
    .clk        (clk),
    .asm_valid  (asm_valid),
    .asm_word   (asm_word),
    .load_state (load_state),
    .loading    (loading),
    .ld_addr    (ld_addr),
    .ld_pmem_we (ld_pmem_we),
    .ld_dmem_we (ld_dmem_we),
    .ld_wdata   (ld_wdata),
    .pmem_size  (pmem_size),
    .dmem_size  (dmem_size)
  );

  mem_port_mux u_mem_port_mux (
    .rst            (rst),
    .clk            (clk),
    .loading        (loading),
    .ld_addr        (ld_addr),
    .ld_pmem_we     (ld_pmem_we),
    .ld_dmem_we     (ld_dmem_we),
    .ld_wdata       (ld_wdata),
    .pmem_size      (pmem_size),
    .dmem_size      (dmem_size),
    .host_valid     (host_valid),
    .host_req       (host_req),
    .host_ready     (host_ready),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp       (host_rsp),
    .pmem_addr      (pmem_addr),
    .pmem_we        (pmem_we),
    .pmem_byt       (pmem_byt),
    .pmem_wdata     (pmem_wdata),
    .pmem_rdata     (pmem_rdata),
    .dmem_addr      (dmem_addr),
    .dmem_we        (dmem_we),
    .dmem_byt       (dmem_byt),
    .dmem_wdata     (dmem_wdata),
    .dmem_rdata     (dmem_rdata)
  );

  // 18 bit instruction words, word addressed
  sync_ram #(.WIDTH(18), .DEPTH(PMEM_DEPTH)) u_pmem (
    .rst   (rst),
    .addr  (pmem_addr),
    .we    (pmem_we),
    .byt   (pmem_byt),
    .wdata (pmem_wdata),
    .rdata (pmem_rdata)
  );

  sync_ram #(.WIDTH(16), .DEPTH(DMEM_DEPTH)) u_dmem (
    .rst   (rst),
    .addr  (dmem_addr),
    .we    (dmem_we),
    .byt   (dmem_byt),
    .wdata (dmem_wdata),
    .rdata (dmem_rdata)
  );

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic rst,  // clock
  output logic clk   // reset, active high
);

  initial begin
    rst = 1'b0;
    forever #(PERIOD / 2) rst = ~rst;
  end

  initial begin
    clk = 1'b1;
    repeat (RESET_CYCLES) @(posedge rst);
    clk <= 1'b0;
  end

endmodule

//--- verification/loader_checker.sv
module loader_checker import mem_map_pkg::*; (
  input  logic        rst,
  input  logic        clk,
  input  logic        byte_ready,
  input  logic        host_valid,
  input  host_req_t   host_req,
  input  logic        host_ready,
  input  logic        host_rsp_valid,
  input  host_rsp_t   host_rsp,
  input  logic        loading,
  input  logic [17:0] exp_rdata,  // expected data of the request on the bus
  input  logic        test_end,
  input  int          test_id,
  output int          n_checks,
  output int          n_errors
);

  logic        rd_pend;
  logic [17:0] rd_exp;
  host_req_t   rd_req;
  logic        in_reset;
  int          base_checks;
  int          base_errors;

  task automatic compare(input string name, input logic [17:0] got, input logic [17:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%05h, expected 0x%05h", name, got, exp);
    end
  endtask

  task automatic report(input string what);
    n_errors++;
    $display("Error: %s", what);
  endtask

  // everything sampled mid cycle
  always @(negedge rst) begin
    if (clk) begin
      in_reset    = 1'b1;
      rd_pend     = 1'b0;
      n_checks    = 0;
      n_errors    = 0;
      base_checks = 0;
      base_errors = 0;
    end else begin
      if (in_reset) begin  // idle outputs right after reset
        compare("loading", 18'(loading), 18'd0);
        compare("byte_ready", 18'(byte_ready), 18'd1);
        compare("host_ready", 18'(host_ready), 18'd1);
        compare("host_rsp_valid", 18'(host_rsp_valid), 18'd0);
        in_reset = 1'b0;
      end
      if (loading && host_ready) report("host bus was ready while an image was loading");
      if (rd_pend && !host_rsp_valid) begin
        report($sformatf("no read response one cycle after the read of 0x%03h", rd_req.addr));
      end else if (!rd_pend && host_rsp_valid) begin
        report("read response came without a read request");
      end else if (rd_pend) begin
        compare($sformatf("host_rsp.rdata (space %0d, addr 0x%03h)", rd_req.space, rd_req.addr),
                host_rsp.rdata, rd_exp);
      end
      rd_pend = host_valid && host_ready && host_req.op == HOST_RD;  // transfers next edge
      rd_req  = host_req;
      rd_exp  = exp_rdata;
      if (test_end) begin
        $display("test %0d: %0d checks, %0d errors", test_id,
                 n_checks - base_checks, n_errors - base_errors);
        base_checks = n_checks;
        base_errors = n_errors;
      end
    end
  end

endmodule

//--- verification/tb_boot_loader.sv
module tb_boot_loader import mem_map_pkg::*; ();

  logic        rst;
  logic        clk;
  logic        byte_valid;
  logic [7:0]  byte_data;
  logic        byte_ready;
  logic        host_valid;
  host_req_t   host_req;
  logic        host_ready;
  logic        host_rsp_valid;
  host_rsp_t   host_rsp;
  logic        loading;
  logic [17:0] exp_rdata;
  logic        test_end;
  int          test_id;
  int          n_checks;
  int          n_errors;

  // tag [35:32], addr [31:20], data [17:0]
  logic [35:0] pat [256];
  logic [31:0] rnd;
  int          idx;
  int          n_bytes;
  int          n_tests;
  int          cycle_limit = 0;

  tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(2)) u_clock_gen (.rst(rst), .clk(clk));

  boot_loader_top #(.DMEM_GVAR_START(12'h100)) u_boot_loader_top (
    .rst            (rst),
    .clk            (clk),
    .byte_valid     (byte_valid),
    .byte_data      (byte_data),
    .byte_ready     (byte_ready),
    .host_valid     (host_valid),
    .host_req       (host_req),
    .host_ready     (host_ready),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp       (host_rsp),
    .loading        (loading)
  );

  loader_checker u_checker (
    .rst            (rst),
    .clk            (clk),
    .byte_ready     (byte_ready),
    .host_valid     (host_valid),
    .host_req       (host_req),
    .host_ready     (host_ready),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp       (host_rsp),
    .loading        (loading),
    .exp_rdata      (exp_rdata),
    .test_end       (test_end),
    .test_id        (test_id),
    .n_checks       (n_checks),
    .n_errors       (n_errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // random idle cycles before each byte
  task automatic send_byte(input logic [7:0] b);
    int gap;
    rnd = xorshift(rnd);
    gap = int'(rnd % 3);
    repeat (gap) begin
      @(posedge rst);
      byte_valid <= 1'b0;
    end
    @(posedge rst);
    byte_valid <= 1'b1;
    byte_data  <= b;
    @(negedge rst);
    while (!byte_ready) @(negedge rst);  // held through LD_FIN
  endtask

  task automatic send_run();
    while (pat[idx][35:32] == 4'h1) begin
      send_byte(pat[idx][7:0]);
      idx++;
    end
    @(posedge rst);
    byte_valid <= 1'b0;
  endtask

  task automatic host_access(input host_op_t op, input host_space_t space,
                             input logic [11:0] addr, input logic [17:0] data, input logic byt);
    @(posedge rst);
    host_valid <= 1'b1;
    host_req   <= '{op: op, space: space, addr: addr, wdata: data[15:0], byt: byt};
    exp_rdata  <= data;
    @(negedge rst);
    while (!host_ready) @(negedge rst);
    @(posedge rst);
    host_valid <= 1'b0;
    if (op == HOST_RD) begin
      @(negedge rst);
      while (!host_rsp_valid) @(negedge rst);
    end
  endtask

  task automatic end_test(input int n);
    @(posedge rst);
    test_end <= 1'b1;
    test_id  <= n;
    @(posedge rst);
    test_end <= 1'b0;
    n_tests++;
  endtask

  initial begin
    logic [3:0]  tag;
    logic [11:0] addr;
    logic [17:0] data;
    byte_valid = 1'b0;
    byte_data  = 8'h00;
    host_valid = 1'b0;
    host_req   = '0;
    exp_rdata  = '0;
    test_end   = 1'b0;
    test_id    = 0;
    rnd        = 32'he15b_31b0;
    idx        = 0;
    n_tests    = 0;
    n_bytes    = 0;
    $readmemh("verification/loader_patterns.hex", pat);
    for (int i = 0; i < 256; i++) begin
      if (pat[i][35:32] == 4'h1) n_bytes++;
    end
    cycle_limit = n_bytes * 8 + 200;
    @(negedge clk);
    while (idx < 256 && pat[idx][35:32] != 4'h0) begin
      tag  = pat[idx][35:32];
      addr = pat[idx][31:20];
      data = pat[idx][17:0];
      if (tag == 4'h1) begin
        send_run();
      end else begin
        idx++;
        case (tag)
          4'h2: host_access(HOST_RD, SPACE_PMEM, addr, data, 1'b0);
          4'h3: host_access(HOST_RD, SPACE_DMEM, addr, data, 1'b0);
          4'h4: host_access(HOST_RD, SPACE_STAT, addr, data, 1'b0);
          4'h5: host_access(HOST_WR, SPACE_DMEM, addr, data, 1'b1);
          4'h6: end_test(int'(data));
          4'h7: begin
            fork
              send_run();
              begin  // request goes out once the load is under way
                @(negedge rst);
                while (!loading) @(negedge rst);
                host_access(HOST_RD, SPACE_PMEM, addr, data, 1'b0);
              end
            join
          end
          default: ;
        endcase
      end
    end
    @(posedge rst);
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0 && n_tests > 0) begin
      $display("TB PASSED");
    end else begin
      if (n_tests == 0) $display("the pattern file held no tests");
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge rst);
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- verification/loader_patterns.hex
// columns: tag (1 hex digit), addr (3), data (5); tags 1 stream byte, 2/3/4 read pmem/dmem/status
// with expected data, 5 dmem byte write, 6 end of test, 7 pmem read during next load, 0 stop
// test 1, after reset
400000000 400200000 600000001
// test 2, 4 program words, 6 data bytes
100000055 1000000AA 100000000 100000004 100000000 100000006
100000002 1000000A5 1000000C3 100000001 1000000F0 10000000E
100000003 1000000FF 1000000FF 100000000 100000004 100000081
100000012 100000034 1000000BE 1000000EF 10000000A 100000055
20002A5C3 20011F00E 20023FFFF 200300481
310001234 31020BEEF 310400A55
400200004 400400006 400000000 600000002
// test 3, bad sync then 2 program words, 4 data bytes
100000055 100000012 100000055 1000000AA
100000000 100000002 100000000 100000004
100000001 10000005A 10000005A 100000002 1000000C0 100000001
1000000C0 1000000DE 10000007E 100000081
200015A5A 20012C001 20023FFFF
31000C0DE 310207E81 310400A55
400200002 400400004 600000003
// test 4, read held off until the load ends
70000BEAD 100000055 1000000AA 100000000 100000001 100000000 100000002
100000000 1000000BE 1000000AD 10000005A 1000000A5
310005AA5 400200001 400400002 600000004
// test 5, host byte writes
51030003C 310203C81 510400099 310400A99 310005AA5 600000005
// test 6, no program words
100000055 1000000AA 100000000 100000000 100000000 100000004
100000013 100000057 1000000FA 1000000CE
310001357 31020FACE 310400A99 20000BEAD
400200000 400400004 400000000 600000006
000000000

//--- filelist.f
common/mem_map_pkg.sv
common/img_load_pkg.sv
hw/sync_ram.sv
img_loader/img_word_asm.sv
img_loader/img_load_ctrl.sv
hw/mem_port_mux.sv
hw/boot_loader_top.sv
verification/tb_clock_gen.sv
verification/loader_checker.sv
verification/tb_boot_loader.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module tb_boot_loader -o sim_boot_loader
./obj_dir/sim_boot_loader | tee sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
grep -q "TB PASSED" sim.log
